//--- tb.f
dma_pkg.sv
dma_conf_regs.sv
dma_rr_arb.sv
dma_transfer_id_gen.sv
dma_reg32_2d_frontend.sv
dma_2d_midend.sv
dma_subsys_top.sv
tb_dma_subsys.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_dma_subsys -f tb.f \
  -o sim_dma_subsys \
  && ./obj_dir/sim_dma_subsys > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Simulation finished: PASS" sim.log \
  && echo "run_sim: passed" \
  || { echo "run_sim: failed"; exit 1; }

//--- tb_dma_subsys.sv
`timescale 1ns/1ps

module tb_dma_subsys
  import dma_pkg::*;
();

  typedef struct packed {
    logic [addr_width-1:0] src;
    logic [addr_width-1:0] dst;
    logic [addr_width-1:0] len;
    logic                  decouple;
    logic                  deburst;
  } be_burst_t;

  typedef be_burst_t burst_list_t[$];

  typedef struct packed {
    logic [reg_width-1:0] src;
    logic [reg_width-1:0] dst;
    logic [reg_width-1:0] num_bytes;
    logic [reg_width-1:0] conf;
    logic [reg_width-1:0] stride_src;
    logic [reg_width-1:0] stride_dst;
    logic [reg_width-1:0] num_reps;
  } cfg_t;

  localparam int unsigned reg_timeout  = 200;
  localparam int unsigned idle_timeout = 200;

  logic                                     clk_i;
  logic                                     rst_n_i;
  logic [num_ports-1:0]                     reg_valid_i;
  logic [num_ports-1:0]                     reg_write_i;
  logic [num_ports-1:0][reg_addr_width-1:0] reg_addr_i;
  logic [num_ports-1:0][reg_width-1:0]      reg_wdata_i;
  logic [num_ports-1:0]                     reg_ready_o;
  logic [num_ports-1:0][reg_width-1:0]      reg_rdata_o;
  logic                                     be_valid_o;
  logic [addr_width-1:0]                    be_src_addr_o;
  logic [addr_width-1:0]                    be_dst_addr_o;
  logic [addr_width-1:0]                    be_length_o;
  logic                                     be_decouple_o;
  logic                                     be_deburst_o;
  logic                                     be_ready_i;
  logic                                     be_done_i;

  int unsigned mismatches = 0;
  int unsigned timeouts = 0;
  int unsigned bursts_seen = 0;
  int unsigned cycle = 0;
  bit          bp_on = 1'b0;
  burst_list_t exp_q;
  int unsigned done_due[$];

  dma_subsys_top u_dut (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .reg_valid_i   (reg_valid_i),
    .reg_write_i   (reg_write_i),
    .reg_addr_i    (reg_addr_i),
    .reg_wdata_i   (reg_wdata_i),
    .reg_ready_o   (reg_ready_o),
    .reg_rdata_o   (reg_rdata_o),
    .be_valid_o    (be_valid_o),
    .be_src_addr_o (be_src_addr_o),
    .be_dst_addr_o (be_dst_addr_o),
    .be_length_o   (be_length_o),
    .be_decouple_o (be_decouple_o),
    .be_deburst_o  (be_deburst_o),
    .be_ready_i    (be_ready_i),
    .be_done_i     (be_done_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // expected 1D bursts for one register setup
  function automatic burst_list_t expected_bursts(input cfg_t cfg);
    burst_list_t list;
    be_burst_t   b;
    logic        twod;
    logic [31:0] reps;
    list = {};
    twod = cfg.conf[conf_twod_bit];
    if (cfg.num_bytes == 0 || (twod && cfg.num_reps == 0)) begin
      return list;
    end
    reps = twod ? cfg.num_reps : 32'd1;
    for (int unsigned k = 0; k < reps; k++) begin
      b.src      = cfg.src + k * cfg.stride_src;
      b.dst      = cfg.dst + k * cfg.stride_dst;
      b.len      = cfg.num_bytes;
      b.decouple = cfg.conf[conf_decouple_bit];
      b.deburst  = cfg.conf[conf_deburst_bit];
      list.push_back(b);
    end
    return list;
  endfunction

  function automatic cfg_t build_cfg(input logic [31:0] src, input logic [31:0] dst,
                                     input logic [31:0] num_bytes, input logic [31:0] conf,
                                     input logic [31:0] stride_src,
                                     input logic [31:0] stride_dst,
                                     input logic [31:0] num_reps);
    cfg_t c;
    c.src        = src;
    c.dst        = dst;
    c.num_bytes  = num_bytes;
    c.conf       = conf;
    c.stride_src = stride_src;
    c.stride_dst = stride_dst;
    c.num_reps   = num_reps;
    return c;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("FAIL t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      mismatches++;
    end
  endtask

  // one register access, held until the port answers ready
  task automatic reg_access(input int unsigned port, input logic write,
                            input logic [reg_addr_width-1:0] addr,
                            input logic [reg_width-1:0] wdata,
                            output logic [reg_width-1:0] rdata);
    int unsigned waited;
    waited = 0;
    @(posedge clk_i);
    #1;
    reg_valid_i[port] = 1'b1;
    reg_write_i[port] = write;
    reg_addr_i[port]  = addr;
    reg_wdata_i[port] = wdata;
    @(negedge clk_i);
    while (!reg_ready_o[port] && waited < reg_timeout) begin
      @(negedge clk_i);
      waited++;
    end
    rdata = reg_rdata_o[port];
    if (!reg_ready_o[port]) begin
      $display("timeout: port %0d access to register %0d never completed", port, addr);
      timeouts++;
      rdata = '0;
    end
    @(posedge clk_i);
    #1;
    reg_valid_i[port] = 1'b0;
  endtask

  // program all registers, then read next id to launch
  task automatic launch(input int unsigned port, input cfg_t cfg, output logic [31:0] id);
    burst_list_t exp;
    logic [31:0] unused;
    reg_access(port, 1'b1, reg_src_addr, cfg.src, unused);
    reg_access(port, 1'b1, reg_dst_addr, cfg.dst, unused);
    reg_access(port, 1'b1, reg_num_bytes, cfg.num_bytes, unused);
    reg_access(port, 1'b1, reg_conf, cfg.conf, unused);
    reg_access(port, 1'b1, reg_stride_src, cfg.stride_src, unused);
    reg_access(port, 1'b1, reg_stride_dst, cfg.stride_dst, unused);
    reg_access(port, 1'b1, reg_num_reps, cfg.num_reps, unused);
    reg_access(port, 1'b0, reg_next_id, '0, id);
    exp = expected_bursts(cfg);
    // bursts leave the midend in launch order
    foreach (exp[i]) begin
      exp_q.push_back(exp[i]);
    end
  endtask

  task automatic wait_idle();
    logic [31:0] status;
    int unsigned waited;
    status = 32'd1;
    waited = 0;
    while ((status != 0 || exp_q.size() != 0 || done_due.size() != 0) &&
           waited < idle_timeout) begin
      reg_access(0, 1'b0, reg_status, '0, status);
      waited++;
    end
    if (status != 0 || exp_q.size() != 0 || done_due.size() != 0) begin
      $display("timeout: subsystem did not go idle, %0d bursts still expected", exp_q.size());
      timeouts++;
    end
  endtask

  // backend ready and in-order done pulses
  initial begin
    be_ready_i = 1'b0;
    be_done_i  = 1'b0;
    forever begin
      @(posedge clk_i);
      cycle++;
      #1;
      be_ready_i = bp_on ? ($urandom_range(0, 3) != 0) : 1'b1;
      if (done_due.size() != 0 && done_due[0] <= cycle) begin
        be_done_i = 1'b1;
        void'(done_due.pop_front());
      end else begin
        be_done_i = 1'b0;
      end
    end
  end

  // log accepted bursts and schedule their done after a random delay
  initial begin
    int unsigned due;
    forever begin
      @(negedge clk_i);
      if (be_valid_o && be_ready_i) begin
        bursts_seen++;
        due = cycle + 1 + $urandom_range(0, 4);
        if (done_due.size() != 0 && due <= done_due[$]) begin
          due = done_due[$] + 1;
        end
        done_due.push_back(due);
      end
    end
  end

  initial begin
    be_burst_t exp;
    forever begin
      @(negedge clk_i);
      if (be_valid_o && be_ready_i) begin
        assert (exp_q.size() != 0) else begin
          $display("unexpected burst at t=%0t with no transfer pending", $time);
          mismatches++;
        end
        if (exp_q.size() != 0) begin
          exp = exp_q.pop_front();
          check_value("be_src_addr_o", be_src_addr_o, exp.src);
          check_value("be_dst_addr_o", be_dst_addr_o, exp.dst);
          check_value("be_length_o", be_length_o, exp.len);
          check_value("be_decouple_o", be_decouple_o, exp.decouple);
          check_value("be_deburst_o", be_deburst_o, exp.deburst);
        end
      end
    end
  end

  initial begin
    logic [31:0] rdata;
    logic [31:0] id_a;
    logic [31:0] id_b;
    void'($urandom(27));
    rst_n_i     = 1'b0;
    reg_valid_i = '0;
    reg_write_i = '0;
    reg_addr_i  = '0;
    reg_wdata_i = '0;
    repeat (4) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;

    reg_access(0, 1'b0, reg_status, '0, rdata);
    check_value("reg_status", rdata, 32'd0);
    reg_access(1, 1'b0, reg_done, '0, rdata);
    check_value("reg_done", rdata, 32'd0);
    check_value("be_valid_o", be_valid_o, 32'd0);

    // 1D with both flags where the stride and reps registers are ignored
    launch(0, build_cfg(32'h1000, 32'h8000, 32'h40, 32'h3, 32'h100, 32'h200, 32'd5), id_a);
    check_value("reg_next_id", id_a, 32'd1);
    wait_idle();

    // 2D with six repetitions under back-pressure
    bp_on = 1'b1;
    launch(1, build_cfg(32'h2000, 32'h9000, 32'h20, 32'h4, 32'h40, 32'h80, 32'd6), id_a);
    check_value("reg_next_id", id_a, 32'd2);
    reg_access(1, 1'b0, reg_status, '0, rdata);
    check_value("reg_status", rdata, 32'd1);
    wait_idle();
    reg_access(1, 1'b0, reg_status, '0, rdata);
    check_value("reg_status", rdata, 32'd0);
    reg_access(1, 1'b0, reg_done, '0, rdata);
    check_value("reg_done", rdata, 32'd2);

    launch(0, build_cfg(32'h3000, 32'ha000, 32'h0, 32'h0, 32'h0, 32'h0, 32'd0), id_a);
    check_value("reg_next_id", id_a, 32'd0);
    launch(1, build_cfg(32'h3000, 32'ha000, 32'h10, 32'h4, 32'h8, 32'h8, 32'd0), id_a);
    check_value("reg_next_id", id_a, 32'd0);
    wait_idle();
    check_value("bursts accepted", bursts_seen, 32'd7);

    // both ports at once get ids 3 and 4 in grant order
    fork
      launch(0, build_cfg(32'h4000, 32'hb000, 32'h18, 32'h5, 32'h30, 32'h60, 32'd3), id_a);
      launch(1, build_cfg(32'h5000, 32'hc000, 32'h8, 32'h6, 32'h10, 32'h20, 32'd4), id_b);
    join
    check_value("first launch id", (id_a < id_b) ? id_a : id_b, 32'd3);
    check_value("second launch id", (id_a < id_b) ? id_b : id_a, 32'd4);
    wait_idle();
    reg_access(0, 1'b0, reg_done, '0, rdata);
    check_value("reg_done", rdata, 32'd4);
    check_value("bursts accepted", bursts_seen, 32'd14);

    $display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- dma_subsys_top.sv
`timescale 1ns/1ps

module dma_subsys_top
  import dma_pkg::*;
(
  input  logic                                     clk_i,
  input  logic                                     rst_n_i,
  input  logic [num_ports-1:0]                     reg_valid_i,
  input  logic [num_ports-1:0]                     reg_write_i,
  input  logic [num_ports-1:0][reg_addr_width-1:0] reg_addr_i,
  input  logic [num_ports-1:0][reg_width-1:0]      reg_wdata_i,
  output logic [num_ports-1:0]                     reg_ready_o,
  output logic [num_ports-1:0][reg_width-1:0]      reg_rdata_o,
  output logic                                     be_valid_o,
  output logic [addr_width-1:0]                    be_src_addr_o,
  output logic [addr_width-1:0]                    be_dst_addr_o,
  output logic [addr_width-1:0]                    be_length_o,
  output logic                                     be_decouple_o,
  output logic                                     be_deburst_o,
  input  logic                                     be_ready_i,
  input  logic                                     be_done_i
);

  burst_req_t burst_req;
  logic       burst_valid;
  logic       burst_ready;
  logic       mid_idle;
  logic       trans_complete;

  dma_reg32_2d_frontend u_frontend (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .reg_valid_i      (reg_valid_i),
    .reg_write_i      (reg_write_i),
    .reg_addr_i       (reg_addr_i),
    .reg_wdata_i      (reg_wdata_i),
    .reg_ready_o      (reg_ready_o),
    .reg_rdata_o      (reg_rdata_o),
    .burst_req_o      (burst_req),
    .burst_valid_o    (burst_valid),
    .burst_ready_i    (burst_ready),
    .backend_idle_i   (mid_idle),
    .trans_complete_i (trans_complete)
  );

  dma_2d_midend u_midend (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .burst_req_i      (burst_req),
    .burst_valid_i    (burst_valid),
    .burst_ready_o    (burst_ready),
    .be_valid_o       (be_valid_o),
    .be_src_addr_o    (be_src_addr_o),
    .be_dst_addr_o    (be_dst_addr_o),
    .be_length_o      (be_length_o),
    .be_decouple_o    (be_decouple_o),
    .be_deburst_o     (be_deburst_o),
    .be_ready_i       (be_ready_i),
    .be_done_i        (be_done_i),
    .idle_o           (mid_idle),
    .trans_complete_o (trans_complete)
  );

endmodule

//--- dma_2d_midend.sv
`timescale 1ns/1ps

module dma_2d_midend
  import dma_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  burst_req_t            burst_req_i,
  input  logic                  burst_valid_i,
  output logic                  burst_ready_o,
  output logic                  be_valid_o,
  output logic [addr_width-1:0] be_src_addr_o,
  output logic [addr_width-1:0] be_dst_addr_o,
  output logic [addr_width-1:0] be_length_o,
  output logic                  be_decouple_o,
  output logic                  be_deburst_o,
  input  logic                  be_ready_i,
  input  logic                  be_done_i,
  output logic                  idle_o,
  output logic                  trans_complete_o
);

  // current 2D transfer being cut into 1D bursts
  logic                  active_q;
  logic [addr_width-1:0] src_q;
  logic [addr_width-1:0] dst_q;
  logic [addr_width-1:0] len_q;
  logic                  decouple_q;
  logic                  deburst_q;
  logic [addr_width-1:0] reps_left_q;
  logic [addr_width-1:0] src_stride_q;
  logic [addr_width-1:0] dst_stride_q;

  // repetition counts of issued transfers awaiting their done pulses
  logic [addr_width-1:0]                    q_mem [mid_queue_depth];
  logic [$clog2(mid_queue_depth)-1:0]       wr_ptr_q;
  logic [$clog2(mid_queue_depth)-1:0]       rd_ptr_q;
  logic [$clog2(mid_queue_depth+1)-1:0]     q_cnt_q;
  logic [addr_width-1:0]                    done_cnt_q;
  logic                                     complete_q;
  logic                                     accept;
  logic                                     push;
  logic                                     pop;

  assign burst_ready_o = !active_q && (q_cnt_q != ($clog2(mid_queue_depth+1))'(mid_queue_depth));
  assign accept        = burst_valid_i && burst_ready_o;
  assign push          = accept;
  assign pop           = be_done_i && (done_cnt_q + addr_width'(1) == q_mem[rd_ptr_q]);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      active_q <= 1'b0;
    end else if (accept) begin
      active_q <= 1'b1;
    end else if (be_valid_o && be_ready_i && (reps_left_q == addr_width'(1))) begin
      active_q <= 1'b0;
    end
  end

  // payload follows the request, running addresses step by the strides
  always_ff @(posedge clk_i) begin
    if (accept) begin
      src_q        <= burst_req_i.src_addr;
      dst_q        <= burst_req_i.dst_addr;
      len_q        <= burst_req_i.length;
      decouple_q   <= burst_req_i.decouple;
      deburst_q    <= burst_req_i.deburst;
      reps_left_q  <= burst_req_i.reps;
      src_stride_q <= burst_req_i.src_stride;
      dst_stride_q <= burst_req_i.dst_stride;
    end else if (be_valid_o && be_ready_i) begin
      src_q       <= src_q + src_stride_q;
      dst_q       <= dst_q + dst_stride_q;
      reps_left_q <= reps_left_q - addr_width'(1);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      q_mem[wr_ptr_q] <= burst_req_i.reps;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      q_cnt_q    <= '0;
      done_cnt_q <= '0;
      complete_q <= 1'b0;
    end else begin
      complete_q <= pop;
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q   <= rd_ptr_q + 1'b1;
        done_cnt_q <= '0;
      end else if (be_done_i) begin
        done_cnt_q <= done_cnt_q + addr_width'(1);
      end
      if (push && !pop) begin
        q_cnt_q <= q_cnt_q + 1'b1;
      end else if (pop && !push) begin
        q_cnt_q <= q_cnt_q - 1'b1;
      end
    end
  end

  assign be_valid_o       = active_q;
  assign be_src_addr_o    = src_q;
  assign be_dst_addr_o    = dst_q;
  assign be_length_o      = len_q;
  assign be_decouple_o    = decouple_q;
  assign be_deburst_o     = deburst_q;
  assign trans_complete_o = complete_q;

  // stay busy through the completion pulse so status and done agree
  assign idle_o = !active_q && (q_cnt_q == '0) && !complete_q;

  a_done_has_entry : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    be_done_i |-> (q_cnt_q != '0));

  a_be_hold : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    be_valid_o && !be_ready_i |=> be_valid_o &&
      $stable({be_src_addr_o, be_dst_addr_o, be_length_o, be_decouple_o, be_deburst_o}));

endmodule

//--- dma_reg32_2d_frontend.sv
`timescale 1ns/1ps

module dma_reg32_2d_frontend
  import dma_pkg::*;
(
  input  logic                                     clk_i,
  input  logic                                     rst_n_i,
  input  logic [num_ports-1:0]                     reg_valid_i,
  input  logic [num_ports-1:0]                     reg_write_i,
  input  logic [num_ports-1:0][reg_addr_width-1:0] reg_addr_i,
  input  logic [num_ports-1:0][reg_width-1:0]      reg_wdata_i,
  output logic [num_ports-1:0]                     reg_ready_o,
  output logic [num_ports-1:0][reg_width-1:0]      reg_rdata_o,
  output burst_req_t                               burst_req_o,
  output logic                                     burst_valid_o,
  input  logic                                     burst_ready_i,
  input  logic                                     backend_idle_i,
  input  logic                                     trans_complete_i
);

  logic [num_ports-1:0] arb_valid;
  logic [num_ports-1:0] arb_ready;
  burst_req_t           arb_req [num_ports];
  logic [id_width-1:0]  next_id;
  logic [id_width-1:0]  done_id;
  logic                 busy;
  logic                 issue;

  assign busy = !backend_idle_i;

  for (genvar i = 0; i < num_ports; i++) begin : gen_ports
    dma_conf_regs u_conf_regs (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .reg_valid_i    (reg_valid_i[i]),
      .reg_write_i    (reg_write_i[i]),
      .reg_addr_i     (reg_addr_i[i]),
      .reg_wdata_i    (reg_wdata_i[i]),
      .reg_ready_o    (reg_ready_o[i]),
      .reg_rdata_o    (reg_rdata_o[i]),
      .next_id_i      (next_id),
      .done_id_i      (done_id),
      .busy_i         (busy),
      .launch_ready_i (arb_ready[i]),
      .launch_valid_o (arb_valid[i]),
      .burst_req_o    (arb_req[i])
    );
  end

  // grant reaches the port in the same cycle the midend takes the request
  dma_rr_arb #(
    .payload_t (burst_req_t)
  ) u_arb (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (arb_valid),
    .gnt_o   (arb_ready),
    .data_i  (arb_req),
    .valid_o (burst_valid_o),
    .ready_i (burst_ready_i),
    .data_o  (burst_req_o)
  );

  assign issue = burst_valid_o && burst_ready_i;

  dma_transfer_id_gen u_id_gen (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .issue_i     (issue),
    .retire_i    (trans_complete_i),
    .next_o      (next_id),
    .completed_o (done_id)
  );

endmodule

//--- dma_transfer_id_gen.sv
`timescale 1ns/1ps

module dma_transfer_id_gen
  import dma_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                issue_i,
  input  logic                retire_i,
  output logic [id_width-1:0] next_o,
  output logic [id_width-1:0] completed_o
);

  logic [id_width-1:0] next_q;
  logic [id_width-1:0] completed_q;

  // first transfer gets id 1, id 0 means nothing launched
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      next_q <= id_width'(1);
    end else if (issue_i) begin
      next_q <= next_q + id_width'(1);
    end
  end

  // completions retire in issue order so a plain count is the last done id
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      completed_q <= '0;
    end else if (retire_i) begin
      completed_q <= completed_q + id_width'(1);
    end
  end

  assign next_o      = next_q;
  assign completed_o = completed_q;

endmodule

//--- dma_rr_arb.sv
`timescale 1ns/1ps

module dma_rr_arb
  import dma_pkg::*;
#(
  parameter type payload_t = logic
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic [num_ports-1:0] req_i,
  output logic [num_ports-1:0] gnt_o,
  input  payload_t             data_i [num_ports],
  output logic                 valid_o,
  input  logic                 ready_i,
  output payload_t             data_o
);

  logic [port_idx_width-1:0] rr_q;
  logic [port_idx_width-1:0] idx_q;
  logic                      lock_q;
  logic [port_idx_width-1:0] pick;
  logic [port_idx_width-1:0] sel;

  // search starts one past the port served last
  always_comb begin
    int unsigned cand;
    logic        found;
    pick  = rr_q;
    found = 1'b0;
    for (int unsigned k = 1; k <= num_ports; k++) begin
      cand = (int'(rr_q) + k) % num_ports;
      if (!found && req_i[cand]) begin
        pick  = port_idx_width'(cand);
        found = 1'b1;
      end
    end
  end

  // hold the previous choice while the downstream stalls
  assign sel     = lock_q ? idx_q : pick;
  assign valid_o = req_i[sel];
  assign data_o  = data_i[sel];

  always_comb begin
    gnt_o      = '0;
    gnt_o[sel] = valid_o && ready_i;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rr_q   <= port_idx_width'(num_ports - 1);
      idx_q  <= '0;
      lock_q <= 1'b0;
    end else begin
      lock_q <= valid_o && !ready_i;
      if (valid_o && !ready_i) begin
        idx_q <= sel;
      end
      if (valid_o && ready_i) begin
        rr_q <= sel;
      end
    end
  end

  // a stalled grant keeps its requester and payload
  a_lock_hold : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_o && !ready_i |=> valid_o && $stable(data_o));

endmodule

//--- dma_conf_regs.sv
`timescale 1ns/1ps

module dma_conf_regs
  import dma_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      reg_valid_i,
  input  logic                      reg_write_i,
  input  logic [reg_addr_width-1:0] reg_addr_i,
  input  logic [reg_width-1:0]      reg_wdata_i,
  output logic                      reg_ready_o,
  output logic [reg_width-1:0]      reg_rdata_o,
  input  logic [id_width-1:0]       next_id_i,
  input  logic [id_width-1:0]       done_id_i,
  input  logic                      busy_i,
  input  logic                      launch_ready_i,
  output logic                      launch_valid_o,
  output burst_req_t                burst_req_o
);

  logic [reg_width-1:0] src_addr_q;
  logic [reg_width-1:0] dst_addr_q;
  logic [reg_width-1:0] num_bytes_q;
  logic [reg_width-1:0] conf_q;
  logic [reg_width-1:0] stride_src_q;
  logic [reg_width-1:0] stride_dst_q;
  logic [reg_width-1:0] num_reps_q;
  logic                 twod;
  logic                 cfg_ok;
  logic                 next_id_rd;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      src_addr_q   <= '0;
      dst_addr_q   <= '0;
      num_bytes_q  <= '0;
      conf_q       <= '0;
      stride_src_q <= '0;
      stride_dst_q <= '0;
      num_reps_q   <= '0;
    end else if (reg_valid_i && reg_write_i) begin
      case (reg_addr_i)
        reg_src_addr:   src_addr_q   <= reg_wdata_i;
        reg_dst_addr:   dst_addr_q   <= reg_wdata_i;
        reg_num_bytes:  num_bytes_q  <= reg_wdata_i;
        reg_conf:       conf_q       <= reg_wdata_i;
        reg_stride_src: stride_src_q <= reg_wdata_i;
        reg_stride_dst: stride_dst_q <= reg_wdata_i;
        reg_num_reps:   num_reps_q   <= reg_wdata_i;
        default: ;
      endcase
    end
  end

  assign twod = conf_q[conf_twod_bit];

  // a 2D transfer without repetitions is rejected like a zero length one
  assign cfg_ok = (num_bytes_q != '0) && (!twod || (num_reps_q != '0));

  assign next_id_rd     = reg_valid_i && !reg_write_i && (reg_addr_i == reg_next_id);
  assign launch_valid_o = next_id_rd && cfg_ok;

  // a launching read waits for the grant, everything else completes at once
  assign reg_ready_o = launch_valid_o ? launch_ready_i : 1'b1;

  always_comb begin
    case (reg_addr_i)
      reg_src_addr:   reg_rdata_o = src_addr_q;
      reg_dst_addr:   reg_rdata_o = dst_addr_q;
      reg_num_bytes:  reg_rdata_o = num_bytes_q;
      reg_conf:       reg_rdata_o = conf_q;
      reg_stride_src: reg_rdata_o = stride_src_q;
      reg_stride_dst: reg_rdata_o = stride_dst_q;
      reg_num_reps:   reg_rdata_o = num_reps_q;
      reg_status:     reg_rdata_o = reg_width'(busy_i);
      reg_next_id:    reg_rdata_o = cfg_ok ? reg_width'(next_id_i) : '0;
      reg_done:       reg_rdata_o = reg_width'(done_id_i);
      default:        reg_rdata_o = '0;
    endcase
  end

  always_comb begin
    burst_req_o.src_addr   = src_addr_q;
    burst_req_o.dst_addr   = dst_addr_q;
    burst_req_o.length     = num_bytes_q;
    burst_req_o.decouple   = conf_q[conf_decouple_bit];
    burst_req_o.deburst    = conf_q[conf_deburst_bit];
    // plain 1D transfers run exactly once
    burst_req_o.reps       = twod ? num_reps_q : addr_width'(1);
    burst_req_o.src_stride = stride_src_q;
    burst_req_o.dst_stride = stride_dst_q;
  end

  // a pending launch stays up with an unchanged request until the arbiter takes it
  a_req_stable : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    launch_valid_o && !launch_ready_i |=> launch_valid_o && $stable(burst_req_o));

endmodule

//--- dma_pkg.sv
package dma_pkg;

  // number of register ports in front of the arbiter
  localparam int unsigned num_ports = 2;

  // index into the port arrays, at least one bit wide
  localparam int unsigned port_idx_width = (num_ports > 1) ? $clog2(num_ports) : 1;

  // transfer id counter width
  localparam int unsigned id_width = 8;

  // address, length and stride width
  localparam int unsigned addr_width = 32;

  // register bus widths
  localparam int unsigned reg_addr_width = 4;
  localparam int unsigned reg_width      = 32;

  // register word addresses
  localparam logic [reg_addr_width-1:0] reg_src_addr   = 4'd0;
  localparam logic [reg_addr_width-1:0] reg_dst_addr   = 4'd1;
  localparam logic [reg_addr_width-1:0] reg_num_bytes  = 4'd2;
  localparam logic [reg_addr_width-1:0] reg_conf       = 4'd3;
  localparam logic [reg_addr_width-1:0] reg_stride_src = 4'd4;
  localparam logic [reg_addr_width-1:0] reg_stride_dst = 4'd5;
  localparam logic [reg_addr_width-1:0] reg_num_reps   = 4'd6;
  localparam logic [reg_addr_width-1:0] reg_status     = 4'd7;
  localparam logic [reg_addr_width-1:0] reg_next_id    = 4'd8;
  localparam logic [reg_addr_width-1:0] reg_done       = 4'd9;

  // bit positions inside the configuration register
  localparam int unsigned conf_decouple_bit = 0;
  localparam int unsigned conf_deburst_bit  = 1;
  localparam int unsigned conf_twod_bit     = 2;

  // issued 2D transfers that may wait for completion in the midend
  localparam int unsigned mid_queue_depth = 4;

  // one 2D transfer as handed from the frontend to the midend
  typedef struct packed {
    logic [addr_width-1:0] src_addr;
    logic [addr_width-1:0] dst_addr;
    logic [addr_width-1:0] length;
    logic                  decouple;
    logic                  deburst;
    logic [addr_width-1:0] reps;
    logic [addr_width-1:0] src_stride;
    logic [addr_width-1:0] dst_stride;
  } burst_req_t;

endpackage
